//--- hw/exec_pkg.sv
`default_nettype none

package exec_pkg;

    // ====================
    // encodings
    // ====================

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    typedef enum logic [4:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
        ALU_PASS_B
    } alu_op_e;

    // ====================
    // instruction views
    // ====================

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // the branch offset is scattered around rs1, rs2 and funct3
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        b_fmt_t b_fmt;
    } inst_u;

    // ====================
    // stage payloads
    // ====================

    typedef struct packed {
        inst_u       instruction;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [31:0] pc;
    } exec_req_t;

    typedef struct packed {
        alu_op_e     op;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  rd;
        logic        rd_we;
        logic [31:0] br_imm;
        logic [31:0] pc;
        logic        illegal;
    } alu_req_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] rd_data;
        logic        rd_we;
        logic        branch_taken;
        logic [31:0] branch_target;
        logic        illegal;
    } exec_result_t;

endpackage

`default_nettype wire

//--- hw/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  exec_pkg::exec_req_t in_req,
    output logic                dec_valid,
    input  logic                dec_ready,
    output exec_pkg::alu_req_t  dec_req
);

    exec_pkg::inst_u    inst;
    exec_pkg::alu_req_t dec_next;
    logic [31:0]        imm_i;
    logic [31:0]        imm_b;
    logic [31:0]        imm_u;

    assign inst = in_req.instruction;

    assign imm_i = {{20{inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
    assign imm_b = {{19{inst.b_fmt.imm12}}, inst.b_fmt.imm12, inst.b_fmt.imm11,
                    inst.b_fmt.imm10_5, inst.b_fmt.imm4_1, 1'b0};
    assign imm_u = {inst.i_fmt.imm12, inst.i_fmt.rs1, inst.i_fmt.funct3, 12'h000};

    // ====================
    // decode
    // ====================

    always_comb begin
        dec_next        = '0;
        dec_next.op     = exec_pkg::ALU_NONE;
        dec_next.a      = in_req.rs1_data;
        dec_next.b      = in_req.rs2_data;
        dec_next.rd     = inst.r_fmt.rd;
        dec_next.pc     = in_req.pc;
        case (inst.r_fmt.opcode)
            exec_pkg::OPC_OP: begin
                if (inst.r_fmt.funct7 == 7'h00) begin
                    case (inst.r_fmt.funct3)
                        3'd0: dec_next.op = exec_pkg::ALU_ADD;
                        3'd1: dec_next.op = exec_pkg::ALU_SLL;
                        3'd2: dec_next.op = exec_pkg::ALU_SLT;
                        3'd3: dec_next.op = exec_pkg::ALU_SLTU;
                        3'd4: dec_next.op = exec_pkg::ALU_XOR;
                        3'd5: dec_next.op = exec_pkg::ALU_SRL;
                        3'd6: dec_next.op = exec_pkg::ALU_OR;
                        default: dec_next.op = exec_pkg::ALU_AND;
                    endcase
                end else if (inst.r_fmt.funct7 == 7'h20) begin
                    if (inst.r_fmt.funct3 == 3'd0) dec_next.op = exec_pkg::ALU_SUB;
                    if (inst.r_fmt.funct3 == 3'd5) dec_next.op = exec_pkg::ALU_SRA;
                end
            end
            exec_pkg::OPC_OP_IMM: begin
                dec_next.b = imm_i;
                // shifts reuse the funct7 slot of the immediate
                case (inst.i_fmt.funct3)
                    3'd0: dec_next.op = exec_pkg::ALU_ADD;
                    3'd2: dec_next.op = exec_pkg::ALU_SLT;
                    3'd3: dec_next.op = exec_pkg::ALU_SLTU;
                    3'd4: dec_next.op = exec_pkg::ALU_XOR;
                    3'd6: dec_next.op = exec_pkg::ALU_OR;
                    3'd7: dec_next.op = exec_pkg::ALU_AND;
                    3'd1: begin
                        if (inst.r_fmt.funct7 == 7'h00) dec_next.op = exec_pkg::ALU_SLL;
                    end
                    default: begin
                        if (inst.r_fmt.funct7 == 7'h00) dec_next.op = exec_pkg::ALU_SRL;
                        if (inst.r_fmt.funct7 == 7'h20) dec_next.op = exec_pkg::ALU_SRA;
                    end
                endcase
            end
            exec_pkg::OPC_BRANCH: begin
                // bits 11:7 hold offset bits here, so no destination
                dec_next.rd     = 5'd0;
                dec_next.br_imm = imm_b;
                case (inst.b_fmt.funct3)
                    3'd0: dec_next.op = exec_pkg::ALU_BEQ;
                    3'd1: dec_next.op = exec_pkg::ALU_BNE;
                    3'd4: dec_next.op = exec_pkg::ALU_BLT;
                    3'd5: dec_next.op = exec_pkg::ALU_BGE;
                    3'd6: dec_next.op = exec_pkg::ALU_BLTU;
                    3'd7: dec_next.op = exec_pkg::ALU_BGEU;
                    default: dec_next.op = exec_pkg::ALU_NONE;
                endcase
            end
            exec_pkg::OPC_LUI: begin
                dec_next.b  = imm_u;
                dec_next.op = exec_pkg::ALU_PASS_B;
            end
            default: dec_next.op = exec_pkg::ALU_NONE;
        endcase
        dec_next.illegal = (dec_next.op == exec_pkg::ALU_NONE);
        dec_next.rd_we   = !dec_next.illegal && (inst.r_fmt.opcode != exec_pkg::OPC_BRANCH);
    end

    // ====================
    // request register
    // ====================

    assign in_ready = !dec_valid || dec_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            dec_valid <= 1'b1;
        end else if (dec_ready) begin
            dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            dec_req <= dec_next;
        end
    end

endmodule

`default_nettype wire

//--- hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  exec_pkg::alu_op_e op,
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    output logic [31:0]       result,
    output logic              branch_cond
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        result      = 32'd0;
        branch_cond = 1'b0;
        case (op)
            exec_pkg::ALU_ADD: begin
                result = a + b;
            end
            exec_pkg::ALU_SUB: begin
                result = a - b;
            end
            exec_pkg::ALU_SLL: begin
                result = a << shamt;
            end
            exec_pkg::ALU_SLT: begin
                result[0] = lt_s;
            end
            exec_pkg::ALU_SLTU: begin
                result[0] = lt_u;
            end
            exec_pkg::ALU_XOR: begin
                result = a ^ b;
            end
            exec_pkg::ALU_SRL: begin
                result = a >> shamt;
            end
            exec_pkg::ALU_SRA: begin
                result = $signed(a) >>> shamt;
            end
            exec_pkg::ALU_OR: begin
                result = a | b;
            end
            exec_pkg::ALU_AND: begin
                result = a & b;
            end
            // branch compares only raise the condition, result stays zero
            exec_pkg::ALU_BEQ:  branch_cond = (a == b);
            exec_pkg::ALU_BNE:  branch_cond = (a != b);
            exec_pkg::ALU_BLT:  branch_cond = lt_s;
            exec_pkg::ALU_BGE:  branch_cond = !lt_s;
            exec_pkg::ALU_BLTU: branch_cond = lt_u;
            exec_pkg::ALU_BGEU: branch_cond = !lt_u;
            exec_pkg::ALU_PASS_B: begin
                result = b;
            end
            default: begin
                result      = 32'd0;
                branch_cond = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/exec_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module exec_writeback (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   dec_valid,
    output logic                   dec_ready,
    input  exec_pkg::alu_req_t     dec_req,
    input  logic [31:0]            alu_result,
    input  logic                   branch_cond,
    output logic                   out_valid,
    input  logic                   out_ready,
    output exec_pkg::exec_result_t out_res
);

    exec_pkg::exec_result_t res_next;
    logic [31:0]            target_offset;

    // ====================
    // result assembly
    // ====================

    // branch_cond is never set outside a branch, so other ops fall through to pc + 4
    assign target_offset = branch_cond ? dec_req.br_imm : 32'd4;

    always_comb begin
        res_next               = '0;
        res_next.rd            = dec_req.rd;
        res_next.rd_data       = (dec_req.rd == 5'd0) ? 32'd0 : alu_result;
        res_next.rd_we         = dec_req.rd_we;
        res_next.branch_taken  = branch_cond;
        res_next.branch_target = dec_req.pc + target_offset;
        res_next.illegal       = dec_req.illegal;
    end

    // ====================
    // output register
    // ====================

    assign dec_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (dec_valid && dec_ready) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid && dec_ready) begin
            out_res <= res_next;
        end
    end

endmodule

`default_nettype wire

//--- hw/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  exec_pkg::exec_req_t    in_req,
    output logic                   out_valid,
    input  logic                   out_ready,
    output exec_pkg::exec_result_t out_res
);

    logic               dec_valid;
    logic               dec_ready;
    exec_pkg::alu_req_t dec_req;
    logic [31:0]        alu_result;
    logic               branch_cond;

    inst_decoder inst_decoder_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec_req   (dec_req)
    );

    // the ALU sits between the two registers
    alu alu_i (
        .op          (dec_req.op),
        .a           (dec_req.a),
        .b           (dec_req.b),
        .result      (alu_result),
        .branch_cond (branch_cond)
    );

    exec_writeback exec_writeback_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .dec_valid   (dec_valid),
        .dec_ready   (dec_ready),
        .dec_req     (dec_req),
        .alu_result  (alu_result),
        .branch_cond (branch_cond),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_res     (out_res)
    );

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset is held over four rising edges and released just after the last one
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- test/exec_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit_tb;

    typedef struct {
        string       name;
        logic [31:0] inst;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] rd_data;
        logic        rd_we;
        logic        branch_taken;
        logic [31:0] branch_target;
        logic        illegal;
    } entry_t;

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid;
    logic                   in_ready;
    exec_pkg::exec_req_t    in_req;
    logic                   out_valid;
    logic                   out_ready;
    exec_pkg::exec_result_t out_res;

    entry_t entries[$];
    integer seed;
    int     received;

    tb_clock_gen clock_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    exec_unit exec_unit_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_res   (out_res)
    );

    // ====================
    // instruction words
    // ====================

    // register forms always read x1 and x2
    function automatic logic [31:0] op_word(input logic [6:0] funct7,
                                            input logic [2:0] funct3, input logic [4:0] rd);
        return {funct7, 5'd2, 5'd1, funct3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] imm_word(input logic [11:0] imm,
                                             input logic [2:0] funct3, input logic [4:0] rd);
        return {imm, 5'd1, funct3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] br_word(input logic [12:0] off, input logic [2:0] funct3);
        return {off[12], off[10:5], 5'd2, 5'd1, funct3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    // ====================
    // table
    // ====================

    task automatic add_entry(input string name, input logic [31:0] inst,
                             input logic [31:0] a, input logic [31:0] b, input logic [31:0] pc,
                             input logic [4:0] rd, input logic [31:0] rd_data, input logic we,
                             input logic taken, input logic [31:0] target, input logic illegal);
        entry_t e;
        e.name          = name;
        e.inst          = inst;
        e.rs1_data      = a;
        e.rs2_data      = b;
        e.pc            = pc;
        e.rd            = rd;
        e.rd_data       = rd_data;
        e.rd_we         = we;
        e.branch_taken  = taken;
        e.branch_target = target;
        e.illegal       = illegal;
        entries.push_back(e);
    endtask

    task automatic alu_case(input string name, input logic [31:0] inst, input logic [31:0] a,
                            input logic [31:0] b, input logic [4:0] rd, input logic [31:0] data);
        add_entry(name, inst, a, b, 32'h100, rd, data, 1'b1, 1'b0, 32'h104, 1'b0);
    endtask

    task automatic branch_case(input string name, input logic [31:0] inst, input logic [31:0] a,
                               input logic [31:0] b, input logic [31:0] pc, input logic taken,
                               input logic [31:0] target);
        add_entry(name, inst, a, b, pc, 5'd0, 32'd0, 1'b0, taken, target, 1'b0);
    endtask

    task automatic illegal_case(input string name, input logic [31:0] inst, input logic [4:0] rd);
        add_entry(name, inst, 32'd10, 32'd20, 32'h200, rd, 32'd0, 1'b0, 1'b0, 32'h204, 1'b1);
    endtask

    task automatic fill_entries();
        alu_case("add", op_word(7'h00, 3'd0, 5'd1), 32'd10, 32'd20, 5'd1, 32'd30);
        alu_case("sub_underflow", op_word(7'h20, 3'd0, 5'd2), 32'd5, 32'd7, 5'd2, 32'hFFFF_FFFE);
        alu_case("sll_big_shamt", op_word(7'h00, 3'd1, 5'd3), 32'd3, 32'd36, 5'd3, 32'h30);
        alu_case("slt_neg", op_word(7'h00, 3'd2, 5'd4), 32'hFFFF_FFFF, 32'd1, 5'd4, 32'd1);
        alu_case("sltu_max", op_word(7'h00, 3'd3, 5'd5), 32'hFFFF_FFFF, 32'd1, 5'd5, 32'd0);
        alu_case("xor", op_word(7'h00, 3'd4, 5'd6), 32'hF0F0_F0F0, 32'h0FF0_0FF0, 5'd6,
                 32'hFF00_FF00);
        alu_case("srl_neg", op_word(7'h00, 3'd5, 5'd7), 32'h8000_0000, 32'd4, 5'd7, 32'h0800_0000);
        alu_case("sra_neg", op_word(7'h20, 3'd5, 5'd8), 32'h8000_0000, 32'd4, 5'd8, 32'hF800_0000);
        alu_case("sra_big_shamt", op_word(7'h20, 3'd5, 5'd9), 32'h8000_0000, 32'hFFFF_FFE4, 5'd9,
                 32'hF800_0000);
        alu_case("or", op_word(7'h00, 3'd6, 5'd10), 32'hF0F0_0000, 32'h0000_F0F0, 5'd10,
                 32'hF0F0_F0F0);
        alu_case("and", op_word(7'h00, 3'd7, 5'd11), 32'hFF00_FF00, 32'h0FF0_0FF0, 5'd11,
                 32'h0F00_0F00);
        // rs2_data is junk here so that a missing immediate select shows up
        alu_case("addi_neg", imm_word(12'hFFD, 3'd0, 5'd12), 32'd100, 32'hDEAD_BEEF, 5'd12, 32'd97);
        alu_case("slti", imm_word(12'h001, 3'd2, 5'd13), 32'hFFFF_FFFF, 32'd0, 5'd13, 32'd1);
        alu_case("sltiu_neg_imm", imm_word(12'hFFF, 3'd3, 5'd14), 32'd5, 32'd0, 5'd14, 32'd1);
        alu_case("xori", imm_word(12'hFFF, 3'd4, 5'd15), 32'h0000_FFFF, 32'd0, 5'd15,
                 32'hFFFF_0000);
        alu_case("ori", imm_word(12'h0FF, 3'd6, 5'd16), 32'h100, 32'd0, 5'd16, 32'h1FF);
        alu_case("andi", imm_word(12'h0F0, 3'd7, 5'd17), 32'h1234_5678, 32'd0, 5'd17, 32'h70);
        alu_case("slli", imm_word(12'h008, 3'd1, 5'd18), 32'd1, 32'd0, 5'd18, 32'h100);
        alu_case("srli", imm_word(12'h004, 3'd5, 5'd19), 32'hF000_0000, 32'd0, 5'd19,
                 32'h0F00_0000);
        alu_case("srai", imm_word(12'h404, 3'd5, 5'd20), 32'hF000_0000, 32'd0, 5'd20,
                 32'hFF00_0000);
        alu_case("lui", lui_word(20'h12345, 5'd21), 32'hFFFF_FFFF, 32'd0, 5'd21, 32'h1234_5000);
        alu_case("add_x0", op_word(7'h00, 3'd0, 5'd0), 32'd10, 32'd20, 5'd0, 32'd0);
        illegal_case("illegal_load", {12'h010, 5'd1, 3'd2, 5'd7, 7'b0000011}, 5'd7);
        illegal_case("illegal_funct7", op_word(7'h01, 3'd0, 5'd8), 5'd8);
        branch_case("beq_taken", br_word(13'h0010, 3'd0), 32'd7, 32'd7, 32'h1000, 1'b1, 32'h1010);
        branch_case("beq_not", br_word(13'h0010, 3'd0), 32'd7, 32'd8, 32'h1000, 1'b0, 32'h1004);
        branch_case("beq_far_back", br_word(13'h1000, 3'd0), 32'd3, 32'd3, 32'h2000, 1'b1,
                    32'h1000);
        branch_case("bne_taken", br_word(13'h1FF8, 3'd1), 32'd7, 32'd8, 32'h1000, 1'b1, 32'h0FF8);
        branch_case("bne_not", br_word(13'h1FF8, 3'd1), 32'd7, 32'd7, 32'h1000, 1'b0, 32'h1004);
        branch_case("blt_taken", br_word(13'h0020, 3'd4), 32'hFFFF_FFFF, 32'd1, 32'h1000, 1'b1,
                    32'h1020);
        branch_case("blt_not", br_word(13'h0020, 3'd4), 32'd1, 32'hFFFF_FFFF, 32'h1000, 1'b0,
                    32'h1004);
        branch_case("bge_taken", br_word(13'h0040, 3'd5), 32'd1, 32'hFFFF_FFFF, 32'h1000, 1'b1,
                    32'h1040);
        branch_case("bge_not", br_word(13'h0040, 3'd5), 32'hFFFF_FFFF, 32'd1, 32'h1000, 1'b0,
                    32'h1004);
        branch_case("bltu_taken", br_word(13'h0100, 3'd6), 32'd1, 32'hFFFF_FFFF, 32'h1000, 1'b1,
                    32'h1100);
        branch_case("bltu_not", br_word(13'h0100, 3'd6), 32'hFFFF_FFFF, 32'd1, 32'h1000, 1'b0,
                    32'h1004);
        branch_case("bgeu_taken", br_word(13'h0800, 3'd7), 32'hFFFF_FFFF, 32'd1, 32'h1000, 1'b1,
                    32'h1800);
        branch_case("bgeu_not", br_word(13'h0800, 3'd7), 32'd1, 32'hFFFF_FFFF, 32'h1000, 1'b0,
                    32'h1004);
    endtask

    // ====================
    // checks
    // ====================

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_field(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            abort_run($sformatf("Fail %s %s expected 0x%08h actual 0x%08h",
                                test, field, expected, actual));
        end
    endtask

    task automatic check_result(input entry_t e);
        check_field(e.name, "rd", 32'(e.rd), 32'(out_res.rd));
        check_field(e.name, "rd_data", e.rd_data, out_res.rd_data);
        check_field(e.name, "rd_we", 32'(e.rd_we), 32'(out_res.rd_we));
        check_field(e.name, "branch_taken", 32'(e.branch_taken), 32'(out_res.branch_taken));
        check_field(e.name, "branch_target", e.branch_target, out_res.branch_target);
        check_field(e.name, "illegal", 32'(e.illegal), 32'(out_res.illegal));
    endtask

    // ====================
    // driver and monitor
    // ====================

    task automatic wait_for_reset();
        integer cycles;
        cycles = 0;
        @(posedge clk);
        while (rst_n !== 1'b1) begin
            cycles++;
            if (cycles > 20) abort_run("reset was never released");
            @(posedge clk);
        end
        #2;
    endtask

    // in_ready is sampled mid-cycle, the transfer then happens on the next rising edge
    task automatic drive_one(input entry_t e);
        integer cycles;
        in_valid = 1'b1;
        in_req   = {e.inst, e.rs1_data, e.rs2_data, e.pc};
        cycles   = 0;
        @(negedge clk);
        while (!in_ready) begin
            cycles++;
            if (cycles > 50) abort_run($sformatf("input %s was never accepted", e.name));
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    task automatic check_latency();
        integer cycles;
        out_ready = 1'b1;
        drive_one(entries[0]);
        cycles = 1;
        @(negedge clk);
        while (!out_valid) begin
            cycles++;
            if (cycles > 20) abort_run("first result never came out");
            @(negedge clk);
        end
        check_field("latency", "cycles", 32'd2, cycles);
        check_result(entries[0]);
        received = 1;
        @(posedge clk);
        #2;
    endtask

    task automatic drive_entries();
        for (int i = 1; i < entries.size(); i++) begin
            drive_one(entries[i]);
        end
    endtask

    task automatic collect_results();
        integer idle;
        integer r;
        idle = 0;
        while (received < entries.size()) begin
            r = $random(seed);
            out_ready = (r[1:0] != 2'b00);
            @(negedge clk);
            if (out_valid && out_ready) begin
                check_result(entries[received]);
                received++;
                idle = 0;
            end else begin
                idle++;
                if (idle > 50) abort_run("no result was taken within 50 cycles");
            end
            @(posedge clk);
            #2;
        end
        out_ready = 1'b0;
    endtask

    task automatic check_drained();
        repeat (3) begin
            @(negedge clk);
            assert (!out_valid) else begin
                abort_run("a result came out after the last table entry");
            end
        end
    endtask

    initial begin
        seed      = 39223;
        received  = 0;
        in_valid  = 1'b0;
        in_req    = '0;
        out_ready = 1'b0;
        fill_entries();
        wait_for_reset();
        // nothing has been sent, so the pipeline must be empty and open
        assert (!out_valid && in_ready) else begin
            abort_run("after reset out_valid is not low or in_ready is not high");
        end
        check_latency();
        fork
            drive_entries();
            collect_results();
        join
        // every entry has left, so the pipeline must stay empty
        check_drained();
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
hw/exec_pkg.sv
hw/inst_decoder.sv
hw/alu.sv
hw/exec_writeback.sv
hw/exec_unit.sv
test/tb_clock_gen.sv
test/exec_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := exec_unit_tb
RTL_TOP   := exec_unit
FILELIST  := compile.f
BUILD_DIR := obj_dir

SOURCES   := $(shell cat $(FILELIST))
RTL_FILES := $(filter hw/%,$(SOURCES))

.PHONY: all run lint clean

all: run

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR)
